//--- Makefile
TOP             ?= wb_fabric_tb
SIM_DIR         ?= sim_build
VERILATOR       ?= verilator
FILE_LIST       ?= all.f
VERILATOR_FLAGS ?= --timing --assert
PASS_MSG        := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) \
		--Mdir $(SIM_DIR) -f $(FILE_LIST)

run: build
	@out="$$($(SIM_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(SIM_DIR)

//--- all.f
design/wb_bus_pkg.sv
design/wb_map_pkg.sv
design/bus_protect.sv
design/bus_timeout.sv
design/wbs_arbiter.sv
design/wb_slave_fabric.sv
dv/tb_clk_gen.sv
dv/wb_fabric_tb.sv

//--- design/bus_protect.sv
`timescale 1ns/1ps

module bus_protect #(
  parameter int                    NUM_RESTRICT = 3,
  parameter wb_map_pkg::restrict_t RESTRICTS [NUM_RESTRICT] = '{default: '0}
) (
  input  logic        check_i,  // One-cycle check strobe from the arbiter
  input  logic [15:0] adr_i,
  input  logic        we_i,
  output logic        pass_o,
  output logic        fail_o
);

  logic deny;  // Some valid entry blocks this access

  // ********************************************************************
  // Table scan
  // ********************************************************************

  always_comb begin
    deny = 1'b0;
    for (int k = 0; k < NUM_RESTRICT; k++) begin
      if (RESTRICTS[k].valid &&
          adr_i >= RESTRICTS[k].base &&
          adr_i < RESTRICTS[k].high) begin
        if (we_i ? RESTRICTS[k].deny_wr : RESTRICTS[k].deny_rd) begin
          deny = 1'b1;  // One blocking entry is enough
        end
      end
    end
  end

  // Both answers stay low between checks
  assign fail_o = check_i & deny;
  assign pass_o = check_i & ~deny;

  // The arbiter relies on a single verdict per check
  always_comb begin
    assert (!(pass_o && fail_o))
      else $error("bus_protect gave pass and fail together");
  end

endmodule

//--- design/bus_timeout.sv
`timescale 1ns/1ps

module bus_timeout #(
  parameter int                           NUM_TO     = 2,
  parameter wb_map_pkg::to_conf_t         TO_CONFS [NUM_TO] = '{default: '0},
  parameter logic [wb_map_pkg::TO_W-1:0]  TO_DEFAULT = 20'd1024
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        count_en_i,  // High only while a slave access is outstanding
  input  logic [15:0] adr_i,
  output logic        expired_o
);

  import wb_map_pkg::*;

  logic [TO_W-1:0] limit;    // Limit picked for the live address
  logic [TO_W-1:0] count_q;  // Cycles spent waiting so far
  logic            found;    // An entry already claimed the address

  // ********************************************************************
  // Limit selection
  // ********************************************************************

  always_comb begin
    limit = TO_DEFAULT;
    found = 1'b0;
    for (int k = 0; k < NUM_TO; k++) begin
      if (!found && adr_i >= TO_CONFS[k].base && adr_i < TO_CONFS[k].high) begin
        limit = TO_CONFS[k].limit;  // Earlier entries take priority
        found = 1'b1;
      end
    end
  end

  // ********************************************************************
  // Wait counter
  // ********************************************************************

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !count_en_i) begin
      count_q <= '0;  // Each access starts from zero
    end else if (count_q < limit) begin
      count_q <= count_q + 1'b1;  // Holds once the limit is reached
    end
  end

  assign expired_o = count_en_i && (count_q >= limit);

  // While enabled the count only grows or holds
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    count_en_i |=> count_q >= $past(count_q))
    else $error("bus_timeout counter wrapped");

endmodule

//--- design/wb_bus_pkg.sv
package wb_bus_pkg;

  // ********************************************************************
  // Sizes shared by the master side and the monitor
  // ********************************************************************

  localparam int MASTER_ID_W = 4;  // Width of the master id in the report

  // ********************************************************************
  // Master side
  // ********************************************************************

  typedef struct packed {
    logic        cyc;  // Cycle in progress
    logic        stb;  // Request strobe
    logic        we;   // Write when high
    logic [15:0] adr;  // Byte address
    logic [15:0] dat;  // Write data
  } wbm_req_t;

  typedef struct packed {
    logic [15:0] dat;  // Read data from the active slave
    logic        ack;  // Normal termination
    logic        err;  // Protection fault or timeout
  } wbm_rsp_t;

  // ********************************************************************
  // Slave side and monitor
  // ********************************************************************

  // The per-slave cyc and stb are separate one-hot vectors
  typedef struct packed {
    logic        we;
    logic [15:0] adr;
    logic [15:0] dat;
  } wbs_req_t;

  typedef struct packed {
    logic                   memv;     // Protection violation pulse
    logic                   timeout;  // Slave access timed out
    logic                   we;       // Direction of the reported access
    logic [15:0]            addr;     // Address of the reported access
    logic [MASTER_ID_W-1:0] id;       // Master that issued it
  } bm_report_t;

endpackage

//--- design/wb_map_pkg.sv
package wb_map_pkg;

  // ********************************************************************
  // Address map constants
  // ********************************************************************

  // Windows are 64 bytes aligned, so only bits 15 down to 6 decode
  localparam int PAGE_LSB = 6;
  localparam int TO_W     = 20;  // Width of a timeout limit in cycles

  // ********************************************************************
  // Map entries
  // ********************************************************************

  // A window covers base up to but not including high
  typedef struct packed {
    logic [15:0] base;
    logic [15:0] high;
  } region_t;

  typedef struct packed {
    logic        valid;    // Entry takes part in the check
    logic        deny_rd;  // Reads in the range fault
    logic        deny_wr;  // Writes in the range fault
    logic [15:0] base;
    logic [15:0] high;
  } restrict_t;

  // The first entry that holds the address sets the limit
  typedef struct packed {
    logic [15:0]     base;
    logic [15:0]     high;
    logic [TO_W-1:0] limit;
  } to_conf_t;

endpackage

//--- design/wb_slave_fabric.sv
`timescale 1ns/1ps

module wb_slave_fabric #(
  parameter int                           NUM_SLAVES   = 4,
  parameter int                           NUM_RESTRICT = 3,
  parameter int                           NUM_TO       = 2,
  // Four windows, the last one small
  parameter wb_map_pkg::region_t          REGIONS [NUM_SLAVES] = '{
    '{base: 16'h0000, high: 16'h0100},
    '{base: 16'h0100, high: 16'h0200},
    '{base: 16'h0200, high: 16'h0400},
    '{base: 16'h1000, high: 16'h1040}
  },
  // Write guard, full guard and a spare slot
  parameter wb_map_pkg::restrict_t        RESTRICTS [NUM_RESTRICT] = '{
    '{valid: 1'b1, deny_rd: 1'b0, deny_wr: 1'b1, base: 16'h0180, high: 16'h01c0},
    '{valid: 1'b1, deny_rd: 1'b1, deny_wr: 1'b1, base: 16'h0300, high: 16'h0340},
    '{valid: 1'b0, deny_rd: 1'b0, deny_wr: 1'b0, base: 16'h0000, high: 16'h0000}
  },
  parameter wb_map_pkg::to_conf_t         TO_CONFS [NUM_TO] = '{
    '{base: 16'h1000, high: 16'h1040, limit: 20'd16},
    '{base: 16'h0000, high: 16'h0000, limit: 20'd0}
  },
  parameter logic [wb_map_pkg::TO_W-1:0]  TO_DEFAULT = 20'd256
) (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  wb_bus_pkg::wbm_req_t               wbm_req_i,
  input  logic [wb_bus_pkg::MASTER_ID_W-1:0] wbm_id_i,
  output wb_bus_pkg::wbm_rsp_t               wbm_rsp_o,
  output wb_bus_pkg::wbs_req_t               wbs_req_o,
  output logic [NUM_SLAVES-1:0]              wbs_cyc_o,
  output logic [NUM_SLAVES-1:0]              wbs_stb_o,
  input  logic [NUM_SLAVES-1:0][15:0]        wbs_dat_i,
  input  logic [NUM_SLAVES-1:0]              wbs_ack_i,
  output wb_bus_pkg::bm_report_t             bm_o
);

  wbs_arbiter #(
    .NUM_SLAVES   (NUM_SLAVES),
    .NUM_RESTRICT (NUM_RESTRICT),
    .NUM_TO       (NUM_TO),
    .REGIONS      (REGIONS),
    .RESTRICTS    (RESTRICTS),
    .TO_CONFS     (TO_CONFS),
    .TO_DEFAULT   (TO_DEFAULT)
  ) u_arbiter (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req_i),
    .wbm_id_i  (wbm_id_i),
    .wbm_rsp_o (wbm_rsp_o),
    .wbs_req_o (wbs_req_o),
    .wbs_cyc_o (wbs_cyc_o),
    .wbs_stb_o (wbs_stb_o),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_i (wbs_ack_i),
    .bm_o      (bm_o)
  );

endmodule

//--- design/wbs_arbiter.sv
`timescale 1ns/1ps

module wbs_arbiter #(
  parameter int                           NUM_SLAVES   = 4,
  parameter int                           NUM_RESTRICT = 3,
  parameter int                           NUM_TO       = 2,
  parameter wb_map_pkg::region_t          REGIONS   [NUM_SLAVES]   = '{default: '0},
  parameter wb_map_pkg::restrict_t        RESTRICTS [NUM_RESTRICT] = '{default: '0},
  parameter wb_map_pkg::to_conf_t         TO_CONFS  [NUM_TO]       = '{default: '0},
  parameter logic [wb_map_pkg::TO_W-1:0]  TO_DEFAULT = 20'd1024
) (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  wb_bus_pkg::wbm_req_t               wbm_req_i,
  input  logic [wb_bus_pkg::MASTER_ID_W-1:0] wbm_id_i,
  output wb_bus_pkg::wbm_rsp_t               wbm_rsp_o,
  output wb_bus_pkg::wbs_req_t               wbs_req_o,
  output logic [NUM_SLAVES-1:0]              wbs_cyc_o,
  output logic [NUM_SLAVES-1:0]              wbs_stb_o,
  input  logic [NUM_SLAVES-1:0][15:0]        wbs_dat_i,
  input  logic [NUM_SLAVES-1:0]              wbs_ack_i,
  output wb_bus_pkg::bm_report_t             bm_o
);

  import wb_map_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_VCHECK,
    ST_WAIT
  } arb_state_e;

  arb_state_e            state_q;
  logic [NUM_SLAVES-1:0] sel_d;    // Decoded window for the live address
  logic [NUM_SLAVES-1:0] sel_q;    // Window latched for the access in flight
  logic [NUM_SLAVES-1:0] stb_q;    // One-cycle slave strobe
  logic                  hit;      // A lower window already matched
  logic                  check_q;  // Protection check strobe
  logic                  vpass;
  logic                  vfail;
  logic                  expired;
  logic                  ack_q;
  logic                  err_q;
  logic                  memv_q;
  logic                  tmo_q;
  logic [15:0]           rdata;

  // ********************************************************************
  // Helpers
  // ********************************************************************

  bus_protect #(
    .NUM_RESTRICT (NUM_RESTRICT),
    .RESTRICTS    (RESTRICTS)
  ) u_protect (
    .check_i (check_q),
    .adr_i   (wbm_req_i.adr),
    .we_i    (wbm_req_i.we),
    .pass_o  (vpass),
    .fail_o  (vfail)
  );

  bus_timeout #(
    .NUM_TO     (NUM_TO),
    .TO_CONFS   (TO_CONFS),
    .TO_DEFAULT (TO_DEFAULT)
  ) u_timeout (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .count_en_i (state_q == ST_WAIT),
    .adr_i      (wbm_req_i.adr),
    .expired_o  (expired)
  );

  // ********************************************************************
  // Address decode and read mux
  // ********************************************************************

  always_comb begin
    sel_d = '0;
    hit   = 1'b0;
    for (int k = 0; k < NUM_SLAVES; k++) begin
      if (!hit &&
          wbm_req_i.adr[15:PAGE_LSB] >= REGIONS[k].base[15:PAGE_LSB] &&
          wbm_req_i.adr[15:PAGE_LSB] < REGIONS[k].high[15:PAGE_LSB]) begin
        sel_d[k] = 1'b1;  // Lowest window wins on overlap
        hit      = 1'b1;
      end
    end
  end

  always_comb begin
    rdata = '0;
    for (int k = 0; k < NUM_SLAVES; k++) begin
      if (sel_q[k]) rdata = rdata | wbs_dat_i[k];
    end
  end

  // ********************************************************************
  // Access sequencer
  // ********************************************************************

  always_ff @(posedge wb_clk_i) begin
    check_q <= 1'b0;  // Every output below is a one-cycle pulse
    stb_q   <= '0;
    ack_q   <= 1'b0;
    err_q   <= 1'b0;
    memv_q  <= 1'b0;
    tmo_q   <= 1'b0;
    if (wb_rst_i) begin
      state_q <= ST_IDLE;
      sel_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // Skip the cycle that still shows the last ack or err
          if (wbm_req_i.cyc && wbm_req_i.stb && !ack_q && !err_q) begin
            sel_q   <= sel_d;
            check_q <= 1'b1;
            state_q <= ST_VCHECK;
          end else begin
            sel_q <= '0;  // Cleared one edge after ack so data stays valid
          end
        end
        ST_VCHECK: begin
          if (vpass) begin
            stb_q   <= sel_q;  // Unmapped address strobes nothing and times out
            state_q <= ST_WAIT;
          end else if (vfail) begin
            err_q   <= 1'b1;
            memv_q  <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        ST_WAIT: begin
          if (|(wbs_ack_i & sel_q)) begin
            ack_q   <= 1'b1;
            state_q <= ST_IDLE;
          end else if (expired) begin
            err_q   <= 1'b1;
            tmo_q   <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign wbs_cyc_o = stb_q;
  assign wbs_stb_o = stb_q;
  assign wbs_req_o = '{we: wbm_req_i.we, adr: wbm_req_i.adr, dat: wbm_req_i.dat};
  assign wbm_rsp_o = '{dat: rdata, ack: ack_q, err: err_q};
  assign bm_o      = '{memv: memv_q, timeout: tmo_q, we: wbm_req_i.we,
                       addr: wbm_req_i.adr, id: wbm_id_i};

  // ********************************************************************
  // Checks
  // ********************************************************************

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) $onehot0(sel_q))
    else $error("Slave selection is not one-hot");

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(ack_q && err_q))
    else $error("ack and err raised together");

  // Slaves see a strobe only right after the check passed
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    |stb_q |-> $past(state_q == ST_VCHECK))
    else $error("Slave strobe outside the cycle after vcheck");

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_NS    = 50,  // Half of the 100 ns period
  parameter int RST_CYCLES = 8
) (
  output logic wb_clk_o,
  output logic wb_rst_o
);

  initial begin
    wb_clk_o = 1'b0;
    forever #(HALF_NS) wb_clk_o = ~wb_clk_o;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    wb_rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge wb_clk_o);
    @(negedge wb_clk_o);
    wb_rst_o = 1'b0;
  end

endmodule

//--- dv/wb_fabric_tb.sv
`timescale 1ns/1ps

module wb_fabric_tb;

  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  // ********************************************************************
  // Address map under test
  // ********************************************************************

  localparam region_t TB_REGIONS [4] = '{
    '{base: 16'h0000, high: 16'h0100},
    '{base: 16'h0100, high: 16'h0200},
    '{base: 16'h0200, high: 16'h0400},
    '{base: 16'h1000, high: 16'h1040}  // Short timeout window, page ffc0 stays unmapped
  };
  localparam restrict_t TB_RESTRICTS [3] = '{
    '{valid: 1'b1, deny_rd: 1'b0, deny_wr: 1'b1, base: 16'h0180, high: 16'h01c0},
    '{valid: 1'b1, deny_rd: 1'b1, deny_wr: 1'b1, base: 16'h0300, high: 16'h0340},
    '{valid: 1'b0, deny_rd: 1'b0, deny_wr: 1'b0, base: 16'h0000, high: 16'h0000}
  };
  localparam to_conf_t TB_TO_CONFS [2] = '{
    '{base: 16'h1000, high: 16'h1040, limit: 20'd16},
    '{base: 16'h0000, high: 16'h0000, limit: 20'd0}
  };
  localparam logic [TO_W-1:0] TB_TO_DEFAULT = 20'd64;
  localparam int OUT_ACK  = 0;
  localparam int OUT_MEMV = 1;
  localparam int OUT_TMO  = 2;

  logic             wb_clk;
  logic             wb_rst;
  wbm_req_t         wbm_req;
  logic [3:0]       wbm_id;
  wbm_rsp_t         wbm_rsp;
  wbs_req_t         wbs_req;
  logic [3:0]       wbs_cyc;
  logic [3:0]       wbs_stb;
  logic [3:0][15:0] wbs_dat;
  logic [3:0]       wbs_ack;
  bm_report_t       bm;
  logic [15:0]      smem    [4][128];  // Slave model storage
  logic [15:0]      ref_mem [4][128];  // Reference model copy
  int unsigned      rng_state = 84;
  int               n_err  = 0;
  int               n_txn  = 0;
  int               t_err  = 0;
  int               t_txn  = 0;

  tb_clk_gen u_clk (.wb_clk_o(wb_clk), .wb_rst_o(wb_rst));

  wb_slave_fabric #(
    .NUM_SLAVES (4), .NUM_RESTRICT (3), .NUM_TO (2),
    .REGIONS (TB_REGIONS), .RESTRICTS (TB_RESTRICTS),
    .TO_CONFS (TB_TO_CONFS), .TO_DEFAULT (TB_TO_DEFAULT)
  ) dut (
    .wb_clk_i (wb_clk), .wb_rst_i (wb_rst), .wbm_req_i (wbm_req), .wbm_id_i (wbm_id),
    .wbm_rsp_o (wbm_rsp), .wbs_req_o (wbs_req), .wbs_cyc_o (wbs_cyc), .wbs_stb_o (wbs_stb),
    .wbs_dat_i (wbs_dat), .wbs_ack_i (wbs_ack), .bm_o (bm)
  );

  for (genvar k = 0; k < 4; k++) begin : g_slave
    assign wbs_dat[k] = smem[k][wbs_req.adr[7:1]];  // Slaves always present their word
  end

  // ********************************************************************
  // Random source and reference model
  // ********************************************************************

  function automatic int unsigned rnd();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) & 32'h7fff;
  endfunction

  function automatic int win_of(input logic [15:0] adr);
    for (int k = 0; k < 4; k++) begin
      if (adr[15:6] >= TB_REGIONS[k].base[15:6] && adr[15:6] < TB_REGIONS[k].high[15:6])
        return k;  // Lowest window wins
    end
    return -1;
  endfunction

  function automatic bit denied(input logic [15:0] adr, input logic we);
    bit d;
    d = 1'b0;
    for (int k = 0; k < 3; k++) begin
      if (TB_RESTRICTS[k].valid && adr >= TB_RESTRICTS[k].base && adr < TB_RESTRICTS[k].high &&
          (we ? TB_RESTRICTS[k].deny_wr : TB_RESTRICTS[k].deny_rd)) d = 1'b1;
    end
    return d;
  endfunction

  function automatic logic [TO_W-1:0] limit_of(input logic [15:0] adr);
    for (int k = 0; k < 2; k++) begin
      if (adr >= TB_TO_CONFS[k].base && adr < TB_TO_CONFS[k].high) return TB_TO_CONFS[k].limit;
    end
    return TB_TO_DEFAULT;
  endfunction

  function automatic int stb_index(input logic [3:0] stb);
    for (int k = 0; k < 4; k++) begin
      if (stb[k]) return k;
    end
    return -1;
  endfunction

  // ********************************************************************
  // Compare tasks
  // ********************************************************************

  task automatic note_error();
    n_err++;
    t_err++;
  endtask

  task automatic check_rsp(input wbm_rsp_t exp, input wbm_rsp_t got, input bit with_dat);
    if (got.ack !== exp.ack || got.err !== exp.err || (with_dat && got.dat !== exp.dat)) begin
      $display("mismatch wbm_rsp_o: expected %h, got %h", exp, got);
      note_error();
    end
  endtask

  task automatic check_slave(input wbs_req_t exp, input wbs_req_t got, input int idx,
                             input logic [3:0] got_stb, input logic [3:0] got_cyc);
    logic [3:0] exp_stb;
    exp_stb = (idx >= 0) ? 4'(1 << idx) : 4'h0;
    if (got_stb !== exp_stb) begin
      $display("mismatch wbs_stb_o: expected %h, got %h", exp_stb, got_stb);
      note_error();
    end
    if (got_cyc !== exp_stb) begin
      $display("mismatch wbs_cyc_o: expected %h, got %h", exp_stb, got_cyc);
      note_error();
    end
    if (got !== exp) begin
      $display("mismatch wbs_req_o slave %0d: expected %h, got %h", idx, exp, got);
      note_error();
    end
  endtask

  task automatic check_report(input bm_report_t exp, input bm_report_t got);
    if (got !== exp) begin
      $display("mismatch bm_o: expected %h, got %h", exp, got);
      note_error();
    end
  endtask

  // One cycle with nothing in flight
  task automatic check_quiet();
    @(negedge wb_clk);
    check_rsp('{dat: 16'h0, ack: 1'b0, err: 1'b0}, wbm_rsp, 1'b0);
    check_report('{memv: 1'b0, timeout: 1'b0, we: wbm_req.we, addr: wbm_req.adr, id: wbm_id}, bm);
    if (wbs_stb !== 4'h0) begin
      $display("mismatch wbs_stb_o: expected 0, got %h", wbs_stb);
      note_error();
    end
    if (wbs_cyc !== 4'h0) begin
      $display("mismatch wbs_cyc_o: expected 0, got %h", wbs_cyc);
      note_error();
    end
  endtask

  // ********************************************************************
  // Stimulus
  // ********************************************************************

  // Kind 0 mapped and allowed, 1 protected, 2 unmapped page, 3 short window
  task automatic pick_addr(input int kind, output logic [15:0] adr, output logic we);
    int          w;
    logic [15:0] span;
    we = 1'(rnd() & 1);
    case (kind)
      0: begin
        w    = int'(rnd() % 4);
        span = TB_REGIONS[w].high - TB_REGIONS[w].base;
        adr  = TB_REGIONS[w].base + 16'(rnd() % span);
        if (denied(adr, we)) adr[8] = ~adr[8];  // Moves out of either guarded range
      end
      1: begin
        if (rnd() % 2 == 0) begin
          adr = 16'h0180 + 16'(rnd() % 64);
          we  = 1'b1;
        end else begin
          adr = 16'h0300 + 16'(rnd() % 64);
        end
      end
      2: adr = 16'hffc0 | 16'(rnd() % 64);
      default: adr = 16'h1000 | 16'(rnd() % 64);
    endcase
  endtask

  task automatic run_txn(input logic [15:0] adr, input logic we, input int delay,
                         input bit withhold);
    wbm_rsp_t    exp_rsp;
    logic [15:0] dat;
    logic [15:0] pend;
    int          outcome;
    int          exp_win;
    int          got_win;
    int          exp_stbs;
    int          stbs;
    int          count;
    int          cycles;
    int          limit;
    bit          done;
    dat     = 16'(rnd());
    wbm_id  = 4'(rnd());
    exp_win = win_of(adr);
    limit   = int'(limit_of(adr));
    if (denied(adr, we)) outcome = OUT_MEMV;
    else if (exp_win < 0 || withhold) outcome = OUT_TMO;
    else outcome = OUT_ACK;
    exp_stbs = (outcome != OUT_MEMV && exp_win >= 0) ? 1 : 0;
    wbm_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    stbs     = 0;
    count    = -1;
    cycles   = 0;
    done     = 1'b0;
    got_win  = -1;
    pend     = 16'h0;
    while (!done && cycles < limit + 20) begin
      @(negedge wb_clk);
      cycles++;
      wbs_ack = 4'h0;  // Slave acks last one cycle
      if (wbm_rsp.ack || wbm_rsp.err) begin
        done = 1'b1;
      end else begin
        if (|wbs_stb || |wbs_cyc) begin
          stbs++;
          got_win = stb_index(wbs_stb);
          check_slave('{we: we, adr: adr, dat: dat}, wbs_req, exp_win, wbs_stb, wbs_cyc);
          pend  = wbs_req.dat;
          count = delay;
        end else if (count > 0) begin
          count--;
        end
        if (count == 0 && !withhold && got_win >= 0) begin
          wbs_ack[got_win] = 1'b1;
          if (we) smem[got_win][adr[7:1]] = pend;  // A slave commits a write as it acks
          count = -1;
        end
      end
    end
    if (!done) begin
      $display("access to %h ended with neither ack nor err within %0d cycles", adr, cycles);
      note_error();
    end else begin
      exp_rsp = '{dat: 16'h0, ack: outcome == OUT_ACK, err: outcome != OUT_ACK};
      if (outcome == OUT_ACK && !we) exp_rsp.dat = ref_mem[exp_win][adr[7:1]];
      check_rsp(exp_rsp, wbm_rsp, outcome == OUT_ACK && !we);
      check_report('{memv: outcome == OUT_MEMV, timeout: outcome == OUT_TMO, we: we,
                     addr: adr, id: wbm_id}, bm);
      if (outcome == OUT_TMO && cycles < limit) begin
        $display("access to %h timed out after %0d cycles, before its limit", adr, cycles);
        note_error();
      end
    end
    if (stbs != exp_stbs) begin
      $display("access to %h strobed slaves %0d times instead of %0d", adr, stbs, exp_stbs);
      note_error();
    end
    if (outcome == OUT_ACK && we) ref_mem[exp_win][adr[7:1]] = dat;
    wbs_ack = 4'h0;
    n_txn++;
    t_txn++;
    check_quiet();  // Request is still held in the cycle after the response
    wbm_req = '0;   // Master drops the cycle after the response
    check_quiet();
  endtask

  task automatic end_test(input string name);
    $display("%-20s %0d transactions, %0d errors", name, t_txn, t_err);
    t_txn = 0;
    t_err = 0;
  endtask

  task automatic wait_reset(output bit ok);
    int cycles;
    cycles = 0;
    while (wb_rst !== 1'b0 && cycles < 20) begin
      @(negedge wb_clk);
      cycles++;
    end
    ok = (wb_rst === 1'b0);
  endtask

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  initial begin
    logic [15:0] adr;
    logic        we;
    int          kind;
    bit          rst_ok;
    wbm_req = '0;
    wbm_id  = 4'h0;
    wbs_ack = 4'h0;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 128; i++) begin
        smem[k][i]    = 16'((k * 128 + i) * 40503) ^ 16'h5a5a;  // Distinct word per location
        ref_mem[k][i] = smem[k][i];
      end
    end
    wait_reset(rst_ok);
    if (!rst_ok) begin
      $display("reset was still asserted after 20 cycles");
    end else begin
      check_quiet();
      end_test("reset state");
      repeat (40) begin
        pick_addr(0, adr, we);
        run_txn(adr, we, int'(rnd() % 8), 1'b0);
      end
      end_test("decode and data");
      repeat (12) begin
        pick_addr(1, adr, we);
        run_txn(adr, we, 0, 1'b0);
      end
      end_test("protection");
      repeat (3) begin
        pick_addr(2, adr, we);
        run_txn(adr, we, 0, 1'b0);
      end
      end_test("unmapped address");
      for (int n = 0; n < 7; n++) begin
        pick_addr(3, adr, we);
        run_txn(adr, we, int'(rnd() % 8), n >= 4);  // Last three slaves never answer
        check_quiet();
      end
      end_test("short timeout");
      repeat (200) begin
        kind = int'(rnd() % 4);
        pick_addr(kind, adr, we);
        run_txn(adr, we, int'(rnd() % 8), kind == 3 && rnd() % 2 == 1);
      end
      end_test("mixed random");
    end
    $display("%0d transactions, %0d errors", n_txn, n_err);
    if (rst_ok && n_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
